//--- sources.f
verilog/rv_pkg.sv
verilog/reg_file.sv
verilog/insn_decode.sv
verilog/alu.sv
verilog/branch_unit.sv
verilog/rv_core.sv
tb/rv_core_chk.sv
tb/tb_rv_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_rv_core
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf $(BUILD_DIR)

//--- tb/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

  localparam int MEM_WORDS = 256;
  localparam int SEED = 68200;
  localparam int TIMEOUT = 500;
  localparam rv_pkg::word_t RESULT_ADDR = 32'h0000_0200;
  localparam rv_pkg::word_t DATA_ADDR = 32'h0000_0100;
  localparam rv_pkg::word_t ECALL = 32'h0000_0073;
  localparam rv_pkg::word_t FENCE = 32'h0ff0_000f;

  logic clk = 1'b0;
  logic rst = 1'b1;
  rv_pkg::word_t insn;
  rv_pkg::word_t dmem_rdata;
  rv_pkg::word_t pc;
  rv_pkg::word_t dmem_addr;
  rv_pkg::word_t dmem_wdata;
  logic dmem_we;
  logic halt;
  logic illegal;

  rv_pkg::word_t imem [MEM_WORDS];
  rv_pkg::word_t dmem [MEM_WORDS];
  rv_pkg::word_t log_addr [$];
  rv_pkg::word_t log_data [$];
  rv_pkg::word_t exp_addr [$];
  rv_pkg::word_t exp_data [$];
  int illegal_cycles;
  int exp_illegal;
  int pc_idx;
  int slot;
  int errors = 0;
  int checks = 0;

  always #20 clk = ~clk;

  rv_core #(.RESET_PC(32'd0)) UUT (
    .clk        (clk),
    .rst        (rst),
    .insn       (insn),
    .dmem_rdata (dmem_rdata),
    .pc         (pc),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_we    (dmem_we),
    .halt       (halt),
    .illegal    (illegal)
  );

  // both memories answer within the cycle
  // a misaligned fetch returns an illegal word
  assign insn = (pc[1:0] == 2'b00) ? imem[pc[9:2]] : 32'hffff_ffff;
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  always @(posedge clk) begin
    if (dmem_we) begin
      dmem[dmem_addr[9:2]] = dmem_wdata;
      log_addr.push_back(dmem_addr);
      log_data.push_back(dmem_wdata);
    end
    if (illegal) begin
      illegal_cycles++;
    end
  end

  // instruction encoders
  function automatic rv_pkg::word_t r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, rv_pkg::op_reg_reg};
  endfunction

  function automatic rv_pkg::word_t i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                           logic [4:0] rd, rv_pkg::opcode_t op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic rv_pkg::word_t s_type(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::op_store};
  endfunction

  function automatic rv_pkg::word_t b_type(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::op_branch};
  endfunction

  function automatic rv_pkg::word_t u_type(logic [19:0] imm, logic [4:0] rd, rv_pkg::opcode_t op);
    return {imm, rd, op};
  endfunction

  function automatic rv_pkg::word_t j_type(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::op_jal};
  endfunction

  function automatic rv_pkg::word_t sign_extend(logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  // reference branch conditions
  function automatic logic branch_taken(logic [2:0] f3, rv_pkg::word_t x, rv_pkg::word_t y);
    case (f3)
      3'd0: return x == y;
      3'd1: return x != y;
      3'd4: return $signed(x) < $signed(y);
      3'd5: return $signed(x) >= $signed(y);
      3'd6: return x < y;
      default: return x >= y;
    endcase
  endfunction

  task automatic check_value(string name, rv_pkg::word_t actual, rv_pkg::word_t expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERROR %s expected %08h actual %08h", name, expected, actual);
    end
  endtask

  task automatic emit(rv_pkg::word_t w);
    imem[pc_idx[7:0]] = w;
    pc_idx++;
  endtask

  task automatic expect_store(rv_pkg::word_t addr, rv_pkg::word_t data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  // x3 goes to the next result slot
  task automatic store_result(rv_pkg::word_t expected);
    emit(s_type(12'(slot * 4), 5'd3, 5'd31));
    expect_store(RESULT_ADDR + rv_pkg::word_t'(slot * 4), expected);
    slot++;
  endtask

  task automatic emit_and_store(rv_pkg::word_t w, rv_pkg::word_t expected);
    emit(w);
    store_result(expected);
  endtask

  // lui and addi, upper part rounded for the signed low half
  task automatic load_const(logic [4:0] rd, rv_pkg::word_t value);
    logic [19:0] upper;
    upper = value[31:12] + 20'(value[11]);
    emit(u_type(upper, rd, rv_pkg::op_lui));
    emit(i_type(value[11:0], rd, 3'b000, rd, rv_pkg::op_reg_imm));
  endtask

  task automatic start_program();
    rst = 1'b1;
    for (int i = 0; i < MEM_WORDS; i++) begin
      // illegal opcode tagged with its index
      imem[i[7:0]] = {i[24:0], 7'b1111111};
      dmem[i[7:0]] = 32'h5a5a_0000 ^ rv_pkg::word_t'(i * 4);
    end
    log_addr.delete();
    log_data.delete();
    exp_addr.delete();
    exp_data.delete();
    illegal_cycles = 0;
    exp_illegal = 0;
    pc_idx = 0;
    slot = 0;
    emit(i_type(RESULT_ADDR[11:0], 5'd0, 3'b000, 5'd31, rv_pkg::op_reg_imm));
  endtask

  task automatic finish_run(string name);
    int cycles;
    cycles = 0;
    repeat (5) @(posedge clk);
    #2;
    rst = 1'b0;
    while (halt !== 1'b1 && cycles < TIMEOUT) begin
      @(posedge clk);
      #2;
      cycles++;
    end
    if (halt !== 1'b1) begin
      errors++;
      $display("%s: the program never halted within %0d cycles", name, TIMEOUT);
    end
    check_value({name, " store count"}, rv_pkg::word_t'(log_addr.size()),
                rv_pkg::word_t'(exp_addr.size()));
    for (int i = 0; i < exp_addr.size() && i < log_addr.size(); i++) begin
      check_value("dmem_addr", log_addr[i], exp_addr[i]);
      check_value("dmem_wdata", log_data[i], exp_data[i]);
    end
    check_value("illegal", rv_pkg::word_t'(illegal_cycles), rv_pkg::word_t'(exp_illegal));
  endtask

  task automatic arith_ops();
    rv_pkg::word_t a;
    rv_pkg::word_t b;
    rv_pkg::word_t ix;
    logic [11:0] imm;
    start_program();
    for (int i = 0; i < 3; i++) begin
      a = $urandom;
      b = $urandom;
      imm = 12'($urandom);
      ix = sign_extend(imm);
      load_const(5'd1, a);
      load_const(5'd2, b);
      emit_and_store(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), a + b);
      emit_and_store(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd3), a - b);
      emit_and_store(r_type(7'h00, 5'd2, 5'd1, 3'b010, 5'd3), {31'd0, $signed(a) < $signed(b)});
      emit_and_store(r_type(7'h00, 5'd2, 5'd1, 3'b011, 5'd3), {31'd0, a < b});
      emit_and_store(r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd3), a ^ b);
      emit_and_store(r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd3), a | b);
      emit_and_store(r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd3), a & b);
      emit_and_store(i_type(imm, 5'd1, 3'b000, 5'd3, rv_pkg::op_reg_imm), a + ix);
      emit_and_store(i_type(imm, 5'd1, 3'b010, 5'd3, rv_pkg::op_reg_imm),
                     {31'd0, $signed(a) < $signed(ix)});
      emit_and_store(i_type(imm, 5'd1, 3'b011, 5'd3, rv_pkg::op_reg_imm), {31'd0, a < ix});
      emit_and_store(i_type(imm, 5'd1, 3'b100, 5'd3, rv_pkg::op_reg_imm), a ^ ix);
      emit_and_store(i_type(imm, 5'd1, 3'b110, 5'd3, rv_pkg::op_reg_imm), a | ix);
      emit_and_store(i_type(imm, 5'd1, 3'b111, 5'd3, rv_pkg::op_reg_imm), a & ix);
    end
    emit(ECALL);
    finish_run("arith");
  endtask

  task automatic shift_ops();
    rv_pkg::word_t a;
    rv_pkg::word_t s;
    logic [4:0] sh;
    start_program();
    for (int i = 0; i < 2; i++) begin
      a = (i == 0) ? ($urandom | 32'h8000_0000) : ($urandom & 32'h7fff_ffff);
      // bit 5 set, so rs2 always holds a count above 31
      s = $urandom | 32'h0000_0020;
      sh = 5'($urandom);
      load_const(5'd1, a);
      load_const(5'd2, s);
      emit_and_store(r_type(7'h00, 5'd2, 5'd1, 3'b001, 5'd3), a << s[4:0]);
      emit_and_store(r_type(7'h00, 5'd2, 5'd1, 3'b101, 5'd3), a >> s[4:0]);
      emit_and_store(r_type(7'h20, 5'd2, 5'd1, 3'b101, 5'd3), $signed(a) >>> s[4:0]);
      emit_and_store(i_type({7'h00, sh}, 5'd1, 3'b001, 5'd3, rv_pkg::op_reg_imm), a << sh);
      emit_and_store(i_type({7'h00, sh}, 5'd1, 3'b101, 5'd3, rv_pkg::op_reg_imm), a >> sh);
      emit_and_store(i_type({7'h20, sh}, 5'd1, 3'b101, 5'd3, rv_pkg::op_reg_imm),
                     $signed(a) >>> sh);
    end
    emit(ECALL);
    finish_run("shift");
  endtask

  task automatic branch_conds();
    rv_pkg::word_t xs [5];
    rv_pkg::word_t ys [5];
    logic [2:0] conds [6];
    logic [11:0] mark;
    start_program();
    xs = '{32'd0, 32'd9, 32'd3, 32'hffff_fff0, 32'd5};
    ys = '{32'd0, 32'd3, 32'd9, 32'd5, 32'hffff_fff0};
    xs[0] = $urandom;
    ys[0] = xs[0];
    conds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    for (int p = 0; p < 5; p++) begin
      load_const(5'd1, xs[p]);
      load_const(5'd2, ys[p]);
      for (int c = 0; c < 6; c++) begin
        // fall-through marker is even, taken marker odd
        mark = 12'(256 + slot * 2);
        emit(b_type(13'd12, 5'd2, 5'd1, conds[c]));
        emit(i_type(mark, 5'd0, 3'b000, 5'd3, rv_pkg::op_reg_imm));
        emit(j_type(21'd8, 5'd0));
        emit(i_type(mark + 12'd1, 5'd0, 3'b000, 5'd3, rv_pkg::op_reg_imm));
        store_result(branch_taken(conds[c], xs[p], ys[p]) ? {20'd0, mark + 12'd1} : {20'd0, mark});
      end
    end
    emit(ECALL);
    finish_run("branch");
  endtask

  task automatic jump_links();
    rv_pkg::word_t here;
    logic [19:0] upper;
    start_program();
    here = rv_pkg::word_t'(pc_idx * 4);
    emit(j_type(21'd8, 5'd3));
    emit(i_type(12'd1, 5'd0, 3'b000, 5'd3, rv_pkg::op_reg_imm));
    store_result(here + 32'd4);
    upper = 20'($urandom);
    here = rv_pkg::word_t'(pc_idx * 4);
    emit(u_type(upper, 5'd3, rv_pkg::op_auipc));
    store_result(here + {upper, 12'd0});
    // jalr sits after the two load_const words and aims one byte past the sw
    here = rv_pkg::word_t'((pc_idx + 2) * 4);
    load_const(5'd4, here + 32'd8 - 32'd2);
    emit(i_type(12'd3, 5'd4, 3'b000, 5'd3, rv_pkg::op_jalr));
    emit(i_type(12'd1, 5'd0, 3'b000, 5'd3, rv_pkg::op_reg_imm));
    store_result(here + 32'd4);
    emit(ECALL);
    finish_run("jump");
  endtask

  task automatic load_store();
    rv_pkg::word_t data [4];
    logic [11:0] delta [4];
    start_program();
    emit(i_type(DATA_ADDR[11:0], 5'd0, 3'b000, 5'd30, rv_pkg::op_reg_imm));
    for (int i = 0; i < 4; i++) begin
      data[i] = $urandom;
      delta[i] = 12'($urandom);
      dmem[8'(64 + i)] = data[i];
      emit(i_type(12'(i * 4), 5'd30, 3'b010, 5'd3, rv_pkg::op_load));
      emit(i_type(delta[i], 5'd3, 3'b000, 5'd3, rv_pkg::op_reg_imm));
      emit(s_type(12'(i * 4), 5'd3, 5'd30));
      expect_store(DATA_ADDR + rv_pkg::word_t'(i * 4), data[i] + sign_extend(delta[i]));
    end
    // read the modified words back
    for (int i = 0; i < 4; i++) begin
      emit(i_type(12'(i * 4), 5'd30, 3'b010, 5'd3, rv_pkg::op_load));
      store_result(data[i] + sign_extend(delta[i]));
    end
    emit(i_type(12'd0, 5'd30, 3'b010, 5'd0, rv_pkg::op_load));
    emit(i_type(12'h123, 5'd0, 3'b000, 5'd0, rv_pkg::op_reg_imm));
    emit_and_store(r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd3), 32'd0);
    emit(ECALL);
    finish_run("load_store");
  endtask

  task automatic halt_and_illegal();
    rv_pkg::word_t here;
    start_program();
    emit_and_store(i_type(12'h055, 5'd0, 3'b000, 5'd3, rv_pkg::op_reg_imm), 32'h55);
    emit(FENCE);
    exp_illegal = 1;
    here = rv_pkg::word_t'(pc_idx * 4);
    emit(ECALL);
    finish_run("halt");
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      #2;
      check_value("pc", pc, here);
      check_value("halt", {31'd0, halt}, 32'd1);
    end
  endtask

  initial begin
    void'($urandom(SEED));
    arith_ops();
    shift_ops();
    branch_conds();
    jump_links();
    load_store();
    halt_and_illegal();
    $display("errors %0d, checks %0d", errors, checks);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/rv_core_chk.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_chk (
  input logic          clk,
  input logic          rst,
  input rv_pkg::word_t pc,
  input logic          dmem_we,
  input logic          halt,
  input logic          illegal
);

  pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else $error("pc %08h is not word aligned", pc);

  // outputs gated while in reset
  reset_quiet: assert property (@(posedge clk) rst |-> !dmem_we && !halt && !illegal)
    else $error("dmem_we, halt or illegal high during reset");

  no_store_on_halt: assert property (@(posedge clk) disable iff (rst) !(halt && dmem_we))
    else $error("halt and dmem_we high together");

  pc_held: assert property (@(posedge clk) disable iff (rst) halt |=> pc == $past(pc))
    else $error("pc moved after halt");

endmodule

bind rv_core rv_core_chk chk (
  .clk     (clk),
  .rst     (rst),
  .pc      (pc),
  .dmem_we (dmem_we),
  .halt    (halt),
  .illegal (illegal)
);

`default_nettype wire

//--- verilog/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core #(
  parameter rv_pkg::word_t RESET_PC = 32'd0
) (
  input  logic          clk,
  input  logic          rst,
  input  rv_pkg::word_t insn,
  input  rv_pkg::word_t dmem_rdata,
  output rv_pkg::word_t pc,
  output rv_pkg::word_t dmem_addr,
  output rv_pkg::word_t dmem_wdata,
  output logic          dmem_we,
  output logic          halt,
  output logic          illegal
);

  rv_pkg::reg_addr_t rs1;
  rv_pkg::reg_addr_t rs2;
  rv_pkg::reg_addr_t rd;
  rv_pkg::word_t     imm;
  rv_pkg::alu_op_t   alu_op;
  logic              alu_b_imm;
  logic              alu_a_pc;
  rv_pkg::wb_sel_t   wb_sel;
  logic              reg_we;
  logic              is_branch;
  logic              is_jal;
  logic              is_jalr;
  logic              mem_write;
  logic              dec_halt;
  logic              dec_illegal;
  rv_pkg::funct3_t   funct3;
  rv_pkg::word_t     rs1_data;
  rv_pkg::word_t     rs2_data;
  rv_pkg::word_t     alu_a;
  rv_pkg::word_t     alu_b;
  rv_pkg::word_t     alu_result;
  rv_pkg::word_t     wb_data;
  rv_pkg::word_t     next_pc;

  // pc holds while an ecall sits at the fetch port
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= RESET_PC;
    end else if (!dec_halt) begin
      pc <= next_pc;
    end
  end

  insn_decode u_decode (
    .insn      (insn),
    .rs1       (rs1),
    .rs2       (rs2),
    .rd        (rd),
    .imm       (imm),
    .alu_op    (alu_op),
    .alu_b_imm (alu_b_imm),
    .alu_a_pc  (alu_a_pc),
    .wb_sel    (wb_sel),
    .reg_we    (reg_we),
    .is_branch (is_branch),
    .is_jal    (is_jal),
    .is_jalr   (is_jalr),
    .mem_write (mem_write),
    .halt      (dec_halt),
    .illegal   (dec_illegal),
    .funct3    (funct3)
  );

  reg_file u_regs (
    .clk      (clk),
    .rst      (rst),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (rd),
    .rd_data  (wb_data),
    .we       (reg_we),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  // operand a is the pc only for auipc
  assign alu_a = alu_a_pc ? pc : rs1_data;
  assign alu_b = alu_b_imm ? imm : rs2_data;

  alu u_alu (
    .op     (alu_op),
    .a      (alu_a),
    .b      (alu_b),
    .result (alu_result)
  );

  branch_unit u_branch (
    .pc          (pc),
    .imm         (imm),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .jalr_target (alu_result),
    .funct3      (funct3),
    .is_branch   (is_branch),
    .is_jal      (is_jal),
    .is_jalr     (is_jalr),
    .next_pc     (next_pc)
  );

  // write-back source
  always_comb begin
    case (wb_sel)
      rv_pkg::wb_imm:  wb_data = imm;
      rv_pkg::wb_pc4:  wb_data = pc + 32'd4;
      rv_pkg::wb_load: wb_data = dmem_rdata;
      default:         wb_data = alu_result;
    endcase
  end

  // data port, address from the ALU sum
  assign dmem_addr  = alu_result;
  assign dmem_wdata = rs2_data;
  assign dmem_we    = mem_write & ~rst;

  assign halt    = dec_halt & ~rst;
  assign illegal = dec_illegal & ~rst;

endmodule

`default_nettype wire

//--- verilog/branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
  input  rv_pkg::word_t   pc,
  input  rv_pkg::word_t   imm,
  input  rv_pkg::word_t   rs1_data,
  input  rv_pkg::word_t   rs2_data,
  input  rv_pkg::word_t   jalr_target,
  input  rv_pkg::funct3_t funct3,
  input  logic            is_branch,
  input  logic            is_jal,
  input  logic            is_jalr,
  output rv_pkg::word_t   next_pc
);

  logic taken;

  // condition from funct3
  always_comb begin
    case (funct3)
      3'b000:  taken = (rs1_data == rs2_data);
      3'b001:  taken = (rs1_data != rs2_data);
      3'b100:  taken = $signed(rs1_data) < $signed(rs2_data);
      3'b101:  taken = $signed(rs1_data) >= $signed(rs2_data);
      3'b110:  taken = rs1_data < rs2_data;
      3'b111:  taken = rs1_data >= rs2_data;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    if (is_jalr) begin
      // jalr target always lands on an even address
      next_pc = {jalr_target[31:1], 1'b0};
    end else if (is_jal || (is_branch && taken)) begin
      next_pc = pc + imm;
    end else begin
      next_pc = pc + 32'd4;
    end
  end

endmodule

`default_nettype wire

//--- verilog/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  rv_pkg::alu_op_t op,
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  output rv_pkg::word_t   result
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // shift amount from the low bits only
  assign shamt = b[4:0];

  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      rv_pkg::alu_add: result = a + b;
      rv_pkg::alu_sub: result = a - b;
      rv_pkg::alu_sll: result = a << shamt;
      rv_pkg::alu_slt: result = {31'd0, lt_signed};
      rv_pkg::alu_sltu: result = {31'd0, lt_unsigned};
      rv_pkg::alu_xor: result = a ^ b;
      rv_pkg::alu_srl: result = a >> shamt;
      // arithmetic shift keeps the sign bit
      rv_pkg::alu_sra: result = $signed(a) >>> shamt;
      rv_pkg::alu_or: result = a | b;
      rv_pkg::alu_and: result = a & b;
      default: result = a + b;
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/insn_decode.sv
`timescale 1ns/1ps
`default_nettype none

module insn_decode (
  input  rv_pkg::word_t     insn,
  output rv_pkg::reg_addr_t rs1,
  output rv_pkg::reg_addr_t rs2,
  output rv_pkg::reg_addr_t rd,
  output rv_pkg::word_t     imm,
  output rv_pkg::alu_op_t   alu_op,
  output logic              alu_b_imm,
  output logic              alu_a_pc,
  output rv_pkg::wb_sel_t   wb_sel,
  output logic              reg_we,
  output logic              is_branch,
  output logic              is_jal,
  output logic              is_jalr,
  output logic              mem_write,
  output logic              halt,
  output logic              illegal,
  output rv_pkg::funct3_t   funct3
);

  rv_pkg::opcode_t opcode;
  logic [6:0]      funct7;
  logic            f7_zero;
  logic            f7_alt;
  rv_pkg::word_t   imm_i;
  rv_pkg::word_t   imm_s;
  rv_pkg::word_t   imm_b;
  rv_pkg::word_t   imm_j;
  rv_pkg::word_t   imm_u;
  rv_pkg::alu_op_t base_op;

  // fixed field positions
  assign opcode = insn[6:0];
  assign rd     = insn[11:7];
  assign funct3 = insn[14:12];
  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];
  assign funct7 = insn[31:25];

  assign f7_zero = (funct7 == 7'd0);
  assign f7_alt  = (funct7 == rv_pkg::funct7_alt);

  // sign-extended immediates per format
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'd0};

  // funct3 to ALU op, before the funct7 alternates
  always_comb begin
    case (funct3)
      3'b000:  base_op = rv_pkg::alu_add;
      3'b001:  base_op = rv_pkg::alu_sll;
      3'b010:  base_op = rv_pkg::alu_slt;
      3'b011:  base_op = rv_pkg::alu_sltu;
      3'b100:  base_op = rv_pkg::alu_xor;
      3'b101:  base_op = rv_pkg::alu_srl;
      3'b110:  base_op = rv_pkg::alu_or;
      default: base_op = rv_pkg::alu_and;
    endcase
  end

  always_comb begin
    imm       = imm_i;
    alu_op    = rv_pkg::alu_add;
    alu_b_imm = 1'b0;
    alu_a_pc  = 1'b0;
    wb_sel    = rv_pkg::wb_alu;
    reg_we    = 1'b0;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    is_jalr   = 1'b0;
    mem_write = 1'b0;
    halt      = 1'b0;
    illegal   = 1'b0;
    case (opcode)
      rv_pkg::op_lui: begin
        imm    = imm_u;
        wb_sel = rv_pkg::wb_imm;
        reg_we = 1'b1;
      end
      rv_pkg::op_auipc: begin
        imm       = imm_u;
        alu_a_pc  = 1'b1;
        alu_b_imm = 1'b1;
        reg_we    = 1'b1;
      end
      rv_pkg::op_jal: begin
        imm    = imm_j;
        is_jal = 1'b1;
        wb_sel = rv_pkg::wb_pc4;
        reg_we = 1'b1;
      end
      rv_pkg::op_jalr: begin
        // target comes from the ALU as rs1 + imm
        alu_b_imm = 1'b1;
        wb_sel    = rv_pkg::wb_pc4;
        is_jalr   = (funct3 == 3'b000);
        reg_we    = (funct3 == 3'b000);
        illegal   = (funct3 != 3'b000);
      end
      rv_pkg::op_branch: begin
        imm       = imm_b;
        is_branch = (funct3[2:1] != 2'b01);
        illegal   = (funct3[2:1] == 2'b01);
      end
      rv_pkg::op_load: begin
        // word access only
        alu_b_imm = 1'b1;
        wb_sel    = rv_pkg::wb_load;
        reg_we    = (funct3 == 3'b010);
        illegal   = (funct3 != 3'b010);
      end
      rv_pkg::op_store: begin
        imm       = imm_s;
        alu_b_imm = 1'b1;
        mem_write = (funct3 == 3'b010);
        illegal   = (funct3 != 3'b010);
      end
      rv_pkg::op_reg_imm: begin
        alu_b_imm = 1'b1;
        alu_op    = (funct3 == 3'b101 && f7_alt) ? rv_pkg::alu_sra : base_op;
        // shift-immediates constrain the upper bits
        if ((funct3 == 3'b001 && !f7_zero) ||
            (funct3 == 3'b101 && !f7_zero && !f7_alt)) begin
          illegal = 1'b1;
        end else begin
          reg_we = 1'b1;
        end
      end
      rv_pkg::op_reg_reg: begin
        if (f7_alt) begin
          alu_op = (funct3 == 3'b000) ? rv_pkg::alu_sub : rv_pkg::alu_sra;
        end else begin
          alu_op = base_op;
        end
        if (f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101))) begin
          reg_we = 1'b1;
        end else begin
          illegal = 1'b1;
        end
      end
      rv_pkg::op_environ: begin
        // only ecall is kept
        halt    = (insn[31:7] == 25'd0);
        illegal = (insn[31:7] != 25'd0);
      end
      default: begin
        illegal = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::reg_addr_t rs1,
  input  rv_pkg::reg_addr_t rs2,
  input  rv_pkg::reg_addr_t rd,
  input  rv_pkg::word_t     rd_data,
  input  logic              we,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data
);

  rv_pkg::word_t regs [32];

  // x0 is never written, so it stays at its reset value
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  // combinational reads, index 0 forced to zero
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- verilog/rv_pkg.sv
`default_nettype none

package rv_pkg;

  // word and field widths
  typedef logic [31:0] word_t;
  typedef logic [4:0] reg_addr_t;
  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;

  // major opcodes of the RV32I base encoding
  localparam opcode_t op_lui = 7'b0110111;
  localparam opcode_t op_auipc = 7'b0010111;
  localparam opcode_t op_jal = 7'b1101111;
  localparam opcode_t op_jalr = 7'b1100111;
  localparam opcode_t op_branch = 7'b1100011;
  localparam opcode_t op_load = 7'b0000011;
  localparam opcode_t op_store = 7'b0100011;
  localparam opcode_t op_reg_imm = 7'b0010011;
  localparam opcode_t op_reg_reg = 7'b0110011;
  localparam opcode_t op_environ = 7'b1110011;

  // funct7 for sub, sra and srai
  localparam logic [6:0] funct7_alt = 7'b0100000;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_t;

  // register write-back source
  typedef enum logic [1:0] {
    wb_alu,
    wb_imm,
    wb_pc4,
    wb_load
  } wb_sel_t;

endpackage

`default_nettype wire
